//--- hdl/wb_pkg.sv
`default_nettype none

package wb_pkg;

    ////////////////////
    // widths
    ////////////////////

    // line address, byte granular
    localparam int ADDR_W = 32;

    // one bus beat
    localparam int BEAT_W = 32;

    // beats per cache line, burst is always this long
    localparam int BEATS = 4;

    localparam int LINE_W = BEATS * BEAT_W;

    ////////////////////
    // queue sizing
    ////////////////////

    localparam int WB_DEPTH = 4;

    // index into the entry array
    localparam int PTR_W = 2;

    ////////////////////
    // writer states
    ////////////////////

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wr_state_t;

endpackage

`default_nettype wire

//--- hdl/wb_queue.sv
`timescale 1ns/100ps
`default_nettype none

module wb_queue (
    input  wire                          clk,
    input  wire                          rstn,

    // cache side push
    input  wire                          in_valid,
    output logic                         in_ready,
    input  wire [wb_pkg::ADDR_W-1:0]     in_addr,
    input  wire [wb_pkg::LINE_W-1:0]     in_data,

    // oldest entry, towards the writer
    output logic                         head_valid,
    output logic [wb_pkg::ADDR_W-1:0]    head_addr,
    output logic [wb_pkg::LINE_W-1:0]    head_data,
    input  wire                          head_done,

    // address search
    input  wire [wb_pkg::ADDR_W-1:0]     query_addr,
    output logic                         query_hit,
    output logic [wb_pkg::LINE_W-1:0]    query_data
);

    ////////////////////
    // storage
    ////////////////////

    logic [wb_pkg::ADDR_W-1:0] addr_mem [wb_pkg::WB_DEPTH];
    logic [wb_pkg::LINE_W-1:0] data_mem [wb_pkg::WB_DEPTH];

    logic [wb_pkg::PTR_W-1:0]  head_ptr;
    logic [wb_pkg::PTR_W-1:0]  tail_ptr;

    // one bit wider than the index so full and empty differ
    logic [wb_pkg::PTR_W:0]    count;

    logic                      push;
    logic                      pop;

    // search scratch
    logic [wb_pkg::PTR_W-1:0]  slot;
    logic [wb_pkg::PTR_W:0]    age;

    assign in_ready   = (count < (wb_pkg::PTR_W + 1)'(wb_pkg::WB_DEPTH));
    assign head_valid = (count != '0);

    assign push = in_valid && in_ready;

    // the entry only leaves once its write response is back
    assign pop = head_done && head_valid;

    assign head_addr = addr_mem[head_ptr];
    assign head_data = data_mem[head_ptr];

    ////////////////////
    // pointers
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload write, slot at tail is free whenever in_ready is high
    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[tail_ptr] <= in_addr;
            data_mem[tail_ptr] <= in_data;
        end
    end

    ////////////////////
    // search
    ////////////////////

    // walk from oldest to newest, a later match overrides,
    // so the entry closest to the tail wins
    always_comb begin
        query_hit  = 1'b0;
        query_data = '0;
        slot       = head_ptr;
        age        = '0;
        for (int i = 0; i < wb_pkg::WB_DEPTH; i++) begin
            slot = head_ptr + wb_pkg::PTR_W'(i);
            age  = (wb_pkg::PTR_W + 1)'(i);
            // empty slots are skipped
            if ((age < count) && (addr_mem[slot] == query_addr)) begin
                query_hit  = 1'b1;
                query_data = data_mem[slot];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/wb_axi_writer.sv
`timescale 1ns/100ps
`default_nettype none

module wb_axi_writer (
    input  wire                          clk,
    input  wire                          rstn,

    // oldest queue entry
    input  wire                          head_valid,
    input  wire [wb_pkg::ADDR_W-1:0]     head_addr,
    input  wire [wb_pkg::LINE_W-1:0]     head_data,
    output logic                         head_done,

    // write address channel
    output logic                         aw_valid,
    input  wire                          aw_ready,
    output logic [wb_pkg::ADDR_W-1:0]    aw_addr,

    // write data channel
    output logic                         w_valid,
    input  wire                          w_ready,
    output logic [wb_pkg::BEAT_W-1:0]    w_data,
    output logic                         w_last,

    // write response channel
    input  wire                          b_valid,
    output logic                         b_ready
);

    wb_pkg::wr_state_t state;
    wb_pkg::wr_state_t state_nxt;

    logic [1:0] beat_cnt;
    logic       last_beat;

    assign last_beat = (beat_cnt == 2'(wb_pkg::BEATS - 1));

    ////////////////////
    // state machine
    ////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= wb_pkg::W_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            wb_pkg::W_IDLE: begin
                if (head_valid) begin
                    state_nxt = wb_pkg::W_ADDR;
                end
            end
            wb_pkg::W_ADDR: begin
                if (aw_ready) begin
                    state_nxt = wb_pkg::W_DATA;
                end
            end
            wb_pkg::W_DATA: begin
                if (w_ready && last_beat) begin
                    state_nxt = wb_pkg::W_RESP;
                end
            end
            wb_pkg::W_RESP: begin
                if (b_valid) begin
                    state_nxt = wb_pkg::W_IDLE;
                end
            end
            default: state_nxt = wb_pkg::W_IDLE;
        endcase
    end

    // beat index within the burst
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (state != wb_pkg::W_DATA) begin
            beat_cnt <= '0;
        end else if (w_ready) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    ////////////////////
    // bus outputs
    ////////////////////

    always_comb begin
        aw_valid  = 1'b0;
        aw_addr   = '0;
        w_valid   = 1'b0;
        w_data    = '0;
        w_last    = 1'b0;
        b_ready   = 1'b0;
        head_done = 1'b0;
        case (state)
            wb_pkg::W_ADDR: begin
                aw_valid = 1'b1;
                aw_addr  = head_addr;
            end
            wb_pkg::W_DATA: begin
                w_valid = 1'b1;
                // lowest word goes first
                w_data  = head_data[beat_cnt * wb_pkg::BEAT_W +: wb_pkg::BEAT_W];
                w_last  = last_beat;
            end
            wb_pkg::W_RESP: begin
                b_ready   = 1'b1;
                head_done = b_valid;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/wb_top.sv
`timescale 1ns/100ps
`default_nettype none

module wb_top (
    input  wire                          clk,
    input  wire                          rstn,

    // cache side
    input  wire                          in_valid,
    output logic                         in_ready,
    input  wire [wb_pkg::ADDR_W-1:0]     in_addr,
    input  wire [wb_pkg::LINE_W-1:0]     in_data,
    input  wire [wb_pkg::ADDR_W-1:0]     query_addr,
    output logic                         query_hit,
    output logic [wb_pkg::LINE_W-1:0]    query_data,

    // memory side
    output logic                         aw_valid,
    input  wire                          aw_ready,
    output logic [wb_pkg::ADDR_W-1:0]    aw_addr,
    output logic                         w_valid,
    input  wire                          w_ready,
    output logic [wb_pkg::BEAT_W-1:0]    w_data,
    output logic                         w_last,
    input  wire                          b_valid,
    output logic                         b_ready
);

    // queue head towards the writer
    logic                      head_valid;
    logic [wb_pkg::ADDR_W-1:0] head_addr;
    logic [wb_pkg::LINE_W-1:0] head_data;
    logic                      head_done;

    wb_queue i_wb_queue (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_addr    (in_addr),
        .in_data    (in_data),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_data  (head_data),
        .head_done  (head_done),
        .query_addr (query_addr),
        .query_hit  (query_hit),
        .query_data (query_data)
    );

    wb_axi_writer i_wb_axi_writer (
        .clk        (clk),
        .rstn       (rstn),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_data  (head_data),
        .head_done  (head_done),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw_addr    (aw_addr),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w_data     (w_data),
        .w_last     (w_last),
        .b_valid    (b_valid),
        .b_ready    (b_ready)
    );

endmodule

`default_nettype wire

//--- verif/wb_chk.sv
`timescale 1ns/100ps
`default_nettype none

module wb_chk (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          aw_valid,
    input  wire                          aw_ready,
    input  wire [wb_pkg::ADDR_W-1:0]     aw_addr,
    input  wire                          w_valid,
    input  wire                          w_ready,
    input  wire [wb_pkg::BEAT_W-1:0]     w_data,
    input  wire                          w_last,
    input  wb_pkg::wr_state_t            wr_state
);

    // accepted beats, modulo the burst length
    logic [1:0] beat_cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (w_valid && w_ready) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        (aw_valid && !aw_ready) |=> (aw_valid && $stable(aw_addr)))
        else $error("aw_valid or aw_addr changed before aw_ready");

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        (w_valid && !w_ready) |=> (w_valid && $stable(w_data)))
        else $error("w_valid or w_data changed before w_ready");

    last_only_valid: assert property (@(posedge clk) disable iff (!rstn)
        w_last |-> w_valid)
        else $error("w_last high without w_valid");

    last_on_fourth: assert property (@(posedge clk) disable iff (!rstn)
        (w_valid && w_ready) |-> (w_last == (beat_cnt == 2'd3)))
        else $error("w_last not on the fourth beat");

    // response phase only after a whole burst
    resp_after_burst: assert property (@(posedge clk) disable iff (!rstn)
        (wr_state == wb_pkg::W_RESP) |-> (beat_cnt == 2'd0))
        else $error("response phase entered before four beats were accepted");

endmodule

bind wb_top wb_chk i_wb_chk (
    .clk      (clk),
    .rstn     (rstn),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw_addr  (aw_addr),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w_data   (w_data),
    .w_last   (w_last),
    .wr_state (i_wb_axi_writer.state)
);

`default_nettype wire

//--- verif/wb_tb.sv
`timescale 1ns/100ps
`default_nettype none

module wb_tb;

    localparam int CLK_NS = 8;

    // cycle budgets per test
    localparam int RESET_CYC  = 20;
    localparam int SINGLE_CYC = 200;
    localparam int SEARCH_CYC = 400;
    localparam int BACKP_CYC  = 600;
    localparam int RANDOM_CYC = 2200;
    localparam int FLIGHT_CYC = 580;

    localparam int WATCHDOG_NS = (RESET_CYC + SINGLE_CYC + SEARCH_CYC + BACKP_CYC
                                  + RANDOM_CYC + FLIGHT_CYC) * CLK_NS;

    logic                       clk = 1'b0;
    logic                       rstn = 1'b0;
    logic                       in_valid = 1'b0;
    logic                       in_ready;
    logic [wb_pkg::ADDR_W-1:0]  in_addr = '0;
    logic [wb_pkg::LINE_W-1:0]  in_data = '0;
    logic [wb_pkg::ADDR_W-1:0]  query_addr = '0;
    logic                       query_hit;
    logic [wb_pkg::LINE_W-1:0]  query_data;
    logic                       aw_valid;
    logic                       aw_ready = 1'b0;
    logic [wb_pkg::ADDR_W-1:0]  aw_addr;
    logic                       w_valid;
    logic                       w_ready = 1'b0;
    logic [wb_pkg::BEAT_W-1:0]  w_data;
    logic                       w_last;
    logic                       b_valid = 1'b0;
    logic                       b_ready;

    // memory model controls and scoreboard
    logic                       aw_block = 1'b0;
    logic                       b_block = 1'b0;
    logic                       random_stall = 1'b0;
    logic [31:0]                lfsr = 32'h7e1a;
    logic [wb_pkg::ADDR_W-1:0]  exp_addr_q [$];
    logic [wb_pkg::LINE_W-1:0]  exp_data_q [$];
    logic [wb_pkg::ADDR_W-1:0]  cur_addr = '0;
    logic [wb_pkg::LINE_W-1:0]  cur_line = '0;
    int beat_idx = 0;
    int pending_b = 0;
    int b_count = 0;
    int b_seen = 0;
    int lines_sent = 0;
    int lines_written = 0;
    int test_errors = 0;
    int resp_errors = 0;

    wb_top i_wb_top (.*);

    initial begin
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [wb_pkg::LINE_W-1:0] line_pattern(input int idx);
        logic [wb_pkg::LINE_W-1:0] pat;
        pat = '0;
        for (int k = 0; k < wb_pkg::BEATS; k++) begin
            pat[k*wb_pkg::BEAT_W +: wb_pkg::BEAT_W] = 32'hc0de_0000 | (32'(idx) << 8) | 32'(k);
        end
        return pat;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, exp, act);
    endtask

    ////////////////////
    // memory responder
    ////////////////////

    // handshakes sampled mid cycle, they complete on the next rising edge
    always @(negedge clk) begin
        if (rstn && aw_valid && aw_ready) begin
            if (exp_addr_q.size() == 0) begin
                $display("ERROR at %0t: write address seen with no line queued", $time);
                resp_errors++;
            end else begin
                cur_addr = exp_addr_q.pop_front();
                cur_line = exp_data_q.pop_front();
                if (aw_addr !== cur_addr) begin
                    report_mismatch("aw_addr", 128'(cur_addr), 128'(aw_addr));
                    resp_errors++;
                end
            end
            beat_idx = 0;
        end
        if (rstn && w_valid && w_ready) begin
            if (w_data !== cur_line[beat_idx*wb_pkg::BEAT_W +: wb_pkg::BEAT_W]) begin
                report_mismatch("w_data",
                    128'(cur_line[beat_idx*wb_pkg::BEAT_W +: wb_pkg::BEAT_W]), 128'(w_data));
                resp_errors++;
            end
            if (w_last !== (beat_idx == wb_pkg::BEATS - 1)) begin
                report_mismatch("w_last", 128'(beat_idx == wb_pkg::BEATS - 1), 128'(w_last));
                resp_errors++;
            end
            beat_idx++;
            if (w_last) begin
                pending_b++;
                lines_written++;
            end
        end
        if (rstn && b_valid && b_ready) begin
            pending_b--;
            b_count++;
        end
    end

    always @(posedge clk) begin
        logic aw_go;
        logic w_go;
        logic b_go;
        #1;
        aw_go = 1'b1;
        w_go  = 1'b1;
        b_go  = 1'b1;
        if (random_stall) begin
            lfsr  = lfsr_next(lfsr);
            aw_go = lfsr[0];
            lfsr  = lfsr_next(lfsr);
            w_go  = lfsr[0];
            lfsr  = lfsr_next(lfsr);
            b_go  = lfsr[0];
        end
        aw_ready = aw_go && !aw_block;
        w_ready  = w_go;
        // a raised response holds until taken
        if (!(b_valid && b_count == b_seen)) begin
            b_valid = b_go && !b_block && (pending_b != 0);
        end
        b_seen = b_count;
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic set_stalls(input logic aw, input logic b, input logic rnd);
        @(negedge clk);
        aw_block     = aw;
        b_block      = b;
        random_stall = rnd;
    endtask

    task automatic push_line(input logic [31:0] addr, input logic [127:0] data);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_addr  = addr;
        in_data  = data;
        @(negedge clk);
        while (!in_ready && n < 1000) begin
            @(negedge clk);
            n++;
        end
        if (in_ready) begin
            exp_addr_q.push_back(addr);
            exp_data_q.push_back(data);
            lines_sent++;
        end else begin
            $display("ERROR at %0t: line %0h was never accepted", $time, addr);
            test_errors++;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_responses(input int target);
        int n;
        n = 0;
        while (b_count < target && n < 1000) begin
            @(negedge clk);
            n++;
        end
        if (b_count < target) begin
            $display("ERROR at %0t: only %0d of %0d write responses", $time, b_count, target);
            test_errors++;
        end
    endtask

    task automatic wait_burst_done();
        int n;
        n = 0;
        while (pending_b == 0 && n < 1000) begin
            @(negedge clk);
            n++;
        end
        if (pending_b == 0) begin
            $display("ERROR at %0t: burst never reached the response phase", $time);
            test_errors++;
        end
    endtask

    task automatic check_query(input logic [31:0] addr, input logic exp_hit,
                               input logic [127:0] exp_data);
        @(posedge clk);
        #1;
        query_addr = addr;
        @(negedge clk);
        if (query_hit !== exp_hit) begin
            report_mismatch("query_hit", 128'(exp_hit), 128'(query_hit));
            test_errors++;
        end
        if (exp_hit && query_data !== exp_data) begin
            report_mismatch("query_data", exp_data, query_data);
            test_errors++;
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_reset_state();
        @(negedge clk);
        if (aw_valid !== 1'b0) begin
            report_mismatch("aw_valid", 128'(1'b0), 128'(aw_valid));
            test_errors++;
        end
        if (w_valid !== 1'b0) begin
            report_mismatch("w_valid", 128'(1'b0), 128'(w_valid));
            test_errors++;
        end
        if (w_last !== 1'b0) begin
            report_mismatch("w_last", 128'(1'b0), 128'(w_last));
            test_errors++;
        end
        if (b_ready !== 1'b0) begin
            report_mismatch("b_ready", 128'(1'b0), 128'(b_ready));
            test_errors++;
        end
        if (query_hit !== 1'b0) begin
            report_mismatch("query_hit", 128'(1'b0), 128'(query_hit));
            test_errors++;
        end
        if (in_ready !== 1'b1) begin
            report_mismatch("in_ready", 128'(1'b1), 128'(in_ready));
            test_errors++;
        end
    endtask

    task automatic test_single_line();
        push_line(32'h0000_1040, line_pattern(50));
        wait_responses(lines_sent);
        if (lines_written != lines_sent) begin
            report_mismatch("lines_written", 128'(lines_sent), 128'(lines_written));
            test_errors++;
        end
        check_query(32'h0000_1040, 1'b0, '0);
    endtask

    task automatic test_search();
        set_stalls(1'b1, 1'b0, 1'b0);
        push_line(32'h0000_2000, line_pattern(100));
        push_line(32'h0000_2040, line_pattern(101));
        push_line(32'h0000_2000, line_pattern(102));
        check_query(32'h0000_2000, 1'b1, line_pattern(102));
        check_query(32'h0000_2040, 1'b1, line_pattern(101));
        check_query(32'h0000_2080, 1'b0, '0);
        set_stalls(1'b0, 1'b0, 1'b0);
        wait_responses(lines_sent);
        check_query(32'h0000_2000, 1'b0, '0);
    endtask

    task automatic test_back_pressure();
        int b_before;
        b_before = b_count;
        set_stalls(1'b1, 1'b0, 1'b0);
        for (int i = 0; i < wb_pkg::WB_DEPTH; i++) begin
            push_line(32'h0000_3000 + (32'(i) << 6), line_pattern(300 + i));
        end
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_addr  = 32'h0000_3400;
        in_data  = line_pattern(310);
        repeat (10) begin
            @(negedge clk);
            if (in_ready !== 1'b0) begin
                report_mismatch("in_ready", 128'(1'b0), 128'(in_ready));
                test_errors++;
            end
        end
        set_stalls(1'b0, 1'b0, 1'b0);
        push_line(32'h0000_3400, line_pattern(310));
        if (b_count <= b_before) begin
            $display("ERROR at %0t: fifth line accepted before any response", $time);
            test_errors++;
        end
        wait_responses(lines_sent);
    endtask

    task automatic test_random_stalls();
        set_stalls(1'b0, 1'b0, 1'b1);
        for (int i = 0; i < 20; i++) begin
            push_line(32'h0002_0000 + (32'(i) << 6), line_pattern(i));
        end
        wait_responses(lines_sent);
        set_stalls(1'b0, 1'b0, 1'b0);
        if (lines_written != lines_sent) begin
            report_mismatch("lines_written", 128'(lines_sent), 128'(lines_written));
            test_errors++;
        end
    endtask

    task automatic test_search_in_flight();
        int b_before;
        set_stalls(1'b0, 1'b1, 1'b0);
        push_line(32'h0000_5000, line_pattern(200));
        wait_burst_done();
        check_query(32'h0000_5000, 1'b1, line_pattern(200));
        // newer copy waits behind the one in flight
        set_stalls(1'b1, 1'b1, 1'b0);
        push_line(32'h0000_5000, line_pattern(201));
        check_query(32'h0000_5000, 1'b1, line_pattern(201));
        b_before = b_count;
        set_stalls(1'b1, 1'b0, 1'b0);
        wait_responses(b_before + 1);
        check_query(32'h0000_5000, 1'b1, line_pattern(201));
        set_stalls(1'b0, 1'b0, 1'b0);
        wait_responses(lines_sent);
        check_query(32'h0000_5000, 1'b0, '0);
    endtask

    initial begin
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_reset_state();
        test_single_line();
        test_search();
        test_back_pressure();
        test_random_stalls();
        test_search_in_flight();
        repeat (4) @(posedge clk);
        $display("errors: tests %0d, bus %0d; lines written %0d of %0d",
                 test_errors, resp_errors, lines_written, lines_sent);
        if (test_errors + resp_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hdl/wb_pkg.sv
hdl/wb_queue.sv
hdl/wb_axi_writer.sv
hdl/wb_top.sv
verif/wb_chk.sv
verif/wb_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module wb_tb -f all.f -o wb_sim

out=$(./obj_dir/wb_sim)
echo "$out"

if echo "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
